// File: build.f
mmio_pkg.sv
mmio_addr_decoder.sv
wb_master.sv
keypad_register.sv
latency_counter.sv
ack_sequencer.sv
mmio_top.sv
tb_wb_ram.sv
tb_mmio.sv

// File: tb_mmio.sv
`timescale 1ns/1ps

module tb_mmio
    import mmio_pkg::*;
();

    localparam int clk_period  = 10;
    localparam int n_ram_words = 8;
    localparam int n_requests  = 2 * n_ram_words + 5;
    localparam int ack_limit   = 50;

    logic        clk;
    logic        reset;
    cpu_req_t    req;
    logic [31:0] memload;
    logic [31:0] instruction;
    logic        d_ack;
    logic        i_ack;
    logic        key_rising;
    logic        key_clear;
    logic [4:0]  key_button;
    logic [1:0]  key_app;
    logic [31:0] display_addr;
    logic [31:0] display_data;
    logic        display_wen;
    logic        display_ack;
    wb_out_t     bus;
    logic        wb_ack;
    logic [31:0] wb_dat_i;

    logic [31:0] lfsr_state;
    logic [31:0] ram_addrs [n_ram_words];
    logic [31:0] ram_model [256];

    mmio_top UUT (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .memload      (memload),
        .instruction  (instruction),
        .d_ack        (d_ack),
        .i_ack        (i_ack),
        .key_rising   (key_rising),
        .key_clear    (key_clear),
        .key_button   (key_button),
        .key_app      (key_app),
        .display_addr (display_addr),
        .display_data (display_data),
        .display_wen  (display_wen),
        .display_ack  (display_ack),
        .bus          (bus),
        .wb_ack       (wb_ack),
        .wb_dat_i     (wb_dat_i)
    );

    tb_wb_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .ack   (wb_ack),
        .dat_o (wb_dat_i)
    );

    always #(clk_period / 2) clk = ~clk;

    // whole run is bounded by the number of requests
    initial begin
        #(n_requests * 200 * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] next;
        next = s >> 1;
        if (s[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time=%0t signal=%s got=%h expected=%h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_request(input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic read, input logic write, input logic fetch);
        @(posedge clk);
        #1;
        req.addr  = addr;
        req.wdata = wdata;
        req.read  = read;
        req.write = write;
        req.fetch = fetch;
    endtask

    // samples on the falling edge and counts cycles up to the ack
    task automatic wait_ack(input logic cyc_low, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cyc_low) begin
                check_value("bus.cyc", bus.cyc, 1'b0);
            end
            if (bus.stb) begin
                check_value("bus.sel", bus.sel, 4'b1111);
            end
            if (cycles > ack_limit) begin
                $display("no acknowledge for address %h within %0d cycles",
                         req.addr, ack_limit);
                $display("Simulation failed");
                $fatal(1, "request timeout");
            end
        end while (!(d_ack || i_ack));
    endtask

    // request is dropped in the cycle after the ack
    task automatic end_request();
        @(posedge clk);
        #1;
        req = '0;
        display_ack = 1'b0;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("d_ack", d_ack, 1'b0);
        check_value("i_ack", i_ack, 1'b0);
        check_value("display_wen", display_wen, 1'b0);
        check_value("bus.cyc", bus.cyc, 1'b0);
        check_value("bus.stb", bus.stb, 1'b0);
    endtask

    task automatic test_ram_write_read();
        logic [31:0] idx;
        logic [31:0] data;
        logic [31:0] addr;
        int          cycles;
        for (int i = 0; i < n_ram_words; i++) begin
            take_bits(8, idx);
            take_bits(32, data);
            addr = {22'b0, idx[7:0], 2'b00};
            ram_addrs[i] = addr;
            ram_model[idx[7:0]] = data;
            drive_request(addr, data, 1'b0, 1'b1, 1'b0);
            wait_ack(1'b0, cycles);
            check_value("d_ack", d_ack, 1'b1);
            check_value("i_ack", i_ack, 1'b0);
            end_request();
        end
        for (int i = 0; i < n_ram_words; i++) begin
            addr = ram_addrs[i];
            drive_request(addr, 32'h0, 1'b1, 1'b0, 1'b0);
            wait_ack(1'b0, cycles);
            check_value("d_ack", d_ack, 1'b1);
            check_value("i_ack", i_ack, 1'b0);
            check_value("memload", memload, ram_model[addr[9:2]]);
            end_request();
        end
    endtask

    task automatic test_fetch();
        logic [31:0] pick;
        logic [31:0] addr;
        int          cycles;
        take_bits(3, pick);
        addr = ram_addrs[pick[2:0]];
        drive_request(addr, 32'h0, 1'b0, 1'b0, 1'b1);
        wait_ack(1'b0, cycles);
        check_value("i_ack", i_ack, 1'b1);
        check_value("d_ack", d_ack, 1'b0);
        check_value("instruction", instruction, ram_model[addr[9:2]]);
        end_request();
    endtask

    task automatic test_keypad();
        logic [31:0] button;
        logic [31:0] app;
        logic [31:0] expected;
        int          cycles;
        take_bits(5, button);
        take_bits(2, app);
        @(posedge clk);
        #1;
        key_button = button[4:0];
        key_app    = app[1:0];
        key_rising = 1'b1;
        @(posedge clk);
        #1;
        key_rising = 1'b0;
        // valid in bit 31, app in 6:5, button in 4:0
        expected = 32'h8000_0000 | (app << 5) | button;
        drive_request(key_addr, 32'h0, 1'b1, 1'b0, 1'b0);
        wait_ack(1'b0, cycles);
        check_value("d_ack", d_ack, 1'b1);
        check_value("key latency", cycles, int'(key_latency) + 2);
        check_value("memload", memload, expected);
        end_request();
        key_clear = 1'b1;
        @(posedge clk);
        #1;
        key_clear = 1'b0;
        drive_request(key_addr, 32'h0, 1'b1, 1'b0, 1'b0);
        wait_ack(1'b0, cycles);
        check_value("d_ack", d_ack, 1'b1);
        check_value("memload", memload, expected & 32'h7fff_ffff);
        end_request();
    endtask

    task automatic test_display();
        logic [31:0] offset;
        logic [31:0] data;
        logic [31:0] hold;
        logic [31:0] addr;
        int          cycles;
        take_bits(14, offset);
        take_bits(32, data);
        take_bits(3, hold);
        addr = disp_base | {offset[13:0], 2'b00};
        drive_request(addr, data, 1'b0, 1'b1, 1'b0);
        @(posedge clk);
        // display_ack held low for 2 to 9 cycles
        for (int i = 0; i < hold + 2; i++) begin
            @(negedge clk);
            check_value("display_wen", display_wen, 1'b1);
            check_value("display_addr", display_addr, addr);
            check_value("display_data", display_data, data);
            check_value("d_ack", d_ack, 1'b0);
        end
        @(posedge clk);
        #1;
        display_ack = 1'b1;
        wait_ack(1'b0, cycles);
        check_value("d_ack", d_ack, 1'b1);
        check_value("i_ack", i_ack, 1'b0);
        end_request();
    endtask

    task automatic test_unmapped();
        logic [31:0] offset;
        int          cycles;
        take_bits(24, offset);
        drive_request(32'h1000_0000 | (offset << 2), 32'h0, 1'b1, 1'b0, 1'b0);
        wait_ack(1'b1, cycles);
        check_value("d_ack", d_ack, 1'b1);
        check_value("unmapped latency", cycles, 2);
        check_value("memload", memload, 32'hdeadbeef);
        end_request();
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        req         = '0;
        key_rising  = 1'b0;
        key_clear   = 1'b0;
        key_button  = '0;
        key_app     = '0;
        display_ack = 1'b0;
        lfsr_state  = 32'hbcef345f;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_ram_write_read();
        test_fetch();
        test_keypad();
        test_display();
        test_unmapped();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tb_wb_ram.sv
`timescale 1ns/1ps

module tb_wb_ram
    import mmio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  wb_out_t     bus,
    output logic        ack,
    output logic [31:0] dat_o
);

    logic [31:0] mem [256];
    logic [7:0]  idx;

    assign idx = bus.adr[9:2];

    // every word differs with its index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
        end
    end

    // one wait cycle, ack drops after the acked edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= bus.cyc && bus.stb && !ack;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cyc && bus.stb && !ack) begin
            if (bus.we) begin
                mem[idx] <= bus.dat;
            end
            dat_o <= mem[idx];
        end
    end

endmodule

// File: mmio_top.sv
`timescale 1ns/1ps

module mmio_top
    import mmio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cpu_req_t    req,
    output logic [31:0] memload,
    output logic [31:0] instruction,
    output logic        d_ack,
    output logic        i_ack,
    input  logic        key_rising,
    input  logic        key_clear,
    input  logic [4:0]  key_button,
    input  logic [1:0]  key_app,
    output logic [31:0] display_addr,
    output logic [31:0] display_data,
    output logic        display_wen,
    input  logic        display_ack,
    output wb_out_t     bus,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_i
);

    region_t     region;
    logic        active;
    logic        wb_start;
    logic        wb_done;
    logic        cnt_load;
    logic        cnt_expired;
    logic [31:0] wb_rdata;
    logic [31:0] key_word;
    logic [31:0] rdata;

    mmio_addr_decoder u_decoder (
        .req    (req),
        .region (region),
        .active (active)
    );

    ack_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .region      (region),
        .active      (active),
        .is_fetch    (req.fetch),
        .wb_start    (wb_start),
        .cnt_load    (cnt_load),
        .wb_done     (wb_done),
        .cnt_expired (cnt_expired),
        .display_ack (display_ack),
        .display_wen (display_wen),
        .d_ack       (d_ack),
        .i_ack       (i_ack)
    );

    latency_counter u_counter (
        .clk         (clk),
        .reset       (reset),
        .cnt_load    (cnt_load),
        .cnt_expired (cnt_expired)
    );

    wb_master u_wb_master (
        .clk      (clk),
        .reset    (reset),
        .wb_start (wb_start),
        .req      (req),
        .bus      (bus),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .rdata    (wb_rdata),
        .wb_done  (wb_done)
    );

    keypad_register u_keypad (
        .clk        (clk),
        .reset      (reset),
        .key_rising (key_rising),
        .key_clear  (key_clear),
        .key_button (key_button),
        .key_app    (key_app),
        .key_word   (key_word)
    );

    // display reads have nothing to return
    always_comb begin
        if (region.ram) begin
            rdata = wb_rdata;
        end else if (region.key) begin
            rdata = key_word;
        end else if (region.none) begin
            rdata = unmapped_word;
        end else begin
            rdata = '0;
        end
    end

    assign memload     = rdata;
    assign instruction = rdata;

    assign display_addr = req.addr;
    assign display_data = req.wdata;

endmodule

// File: ack_sequencer.sv
`timescale 1ns/1ps

module ack_sequencer
    import mmio_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  region_t region,
    input  logic    active,
    input  logic    is_fetch,
    output logic    wb_start,
    output logic    cnt_load,
    input  logic    wb_done,
    input  logic    cnt_expired,
    input  logic    display_ack,
    output logic    display_wen,
    output logic    d_ack,
    output logic    i_ack
);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_bus,
        st_wait_count,
        st_wait_display,
        st_respond
    } state_t;

    state_t state;
    logic   launch;

    assign launch = (state == st_idle) && active;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (active) begin
                        if (region.ram) begin
                            state <= st_wait_bus;
                        end else if (region.key) begin
                            state <= st_wait_count;
                        end else if (region.disp) begin
                            state <= st_wait_display;
                        end else begin
                            state <= st_respond;
                        end
                    end
                end
                st_wait_bus: begin
                    if (wb_done) begin
                        state <= st_respond;
                    end
                end
                st_wait_count: begin
                    if (cnt_expired) begin
                        state <= st_respond;
                    end
                end
                st_wait_display: begin
                    if (display_ack) begin
                        state <= st_respond;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // starts last one cycle since idle is left right away
    assign wb_start = launch && region.ram;
    assign cnt_load = launch && region.key;

    assign display_wen = (state == st_wait_display);

    // request is still held here so fetch picks the ack kind
    assign d_ack = (state == st_respond) && !is_fetch;
    assign i_ack = (state == st_respond) && is_fetch;

    acks_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(d_ack && i_ack));

endmodule

// File: latency_counter.sv
`timescale 1ns/1ps

module latency_counter
    import mmio_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic cnt_load,
    output logic cnt_expired
);

    logic [3:0] count;

    // load restarts even when already counting
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= key_latency;
        end else if (count != 4'd0) begin
            count <= count - 4'd1;
        end
    end

    // last cycle before the count hits zero
    assign cnt_expired = (count == 4'd1) && !cnt_load;

endmodule

// File: keypad_register.sv
`timescale 1ns/1ps

module keypad_register
    import mmio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        key_rising,
    input  logic        key_clear,
    input  logic [4:0]  key_button,
    input  logic [1:0]  key_app,
    output logic [31:0] key_word
);

    logic       valid;
    logic [4:0] button_q;
    logic [1:0] app_q;

    // a new press beats a clear in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (key_rising) begin
            valid <= 1'b1;
        end else if (key_clear) begin
            valid <= 1'b0;
        end
    end

    // last press is kept after clear
    always_ff @(posedge clk) begin
        if (key_rising) begin
            button_q <= key_button;
            app_q    <= key_app;
        end
    end

    always_comb begin
        key_word = '0;
        key_word[key_valid_bit] = valid;
        key_word[key_app_msb:key_app_lsb] = app_q;
        key_word[key_button_msb:key_button_lsb] = button_q;
    end

endmodule

// File: wb_master.sv
`timescale 1ns/1ps

module wb_master
    import mmio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_start,
    input  cpu_req_t    req,
    output wb_out_t     bus,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] rdata,
    output logic        wb_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_transfer,
        st_done
    } state_t;

    state_t      state;
    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            we_q  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (wb_start) begin
                        state <= st_transfer;
                        we_q  <= req.write;
                    end
                end
                st_transfer: begin
                    if (wb_ack) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address and write word held for the whole cycle
    always_ff @(posedge clk) begin
        if (state == st_idle && wb_start) begin
            adr_q <= req.addr;
            dat_q <= req.wdata;
        end
    end

    // read word taken at the acked edge
    always_ff @(posedge clk) begin
        if (state == st_transfer && wb_ack && !we_q) begin
            rdata <= wb_dat_i;
        end
    end

    always_comb begin
        bus.cyc = (state == st_transfer);
        bus.stb = (state == st_transfer);
        bus.we  = (state == st_transfer) && we_q;
        bus.sel = wb_sel_all;
        bus.adr = adr_q;
        bus.dat = dat_q;
    end

    assign wb_done = (state == st_done);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        bus.stb |-> bus.cyc);

    // classic cycle, slave may stall as long as it likes
    stb_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (bus.stb && !wb_ack) |=> (bus.stb && $stable(bus.adr) && $stable(bus.we)));

endmodule

// File: mmio_addr_decoder.sv
`timescale 1ns/1ps

module mmio_addr_decoder
    import mmio_pkg::*;
(
    input  cpu_req_t req,
    output region_t  region,
    output logic     active
);

    logic in_ram;
    logic in_key;
    logic in_disp;

    assign in_ram  = (req.addr >= ram_base) && (req.addr <= ram_limit);
    assign in_key  = (req.addr == key_addr);
    assign in_disp = (req.addr >= disp_base) && (req.addr <= disp_limit);

    // each region decoded on its own
    // none covers every address outside the map
    always_comb begin
        region.ram  = in_ram;
        region.key  = in_key;
        region.disp = in_disp;
        region.none = !(in_ram || in_key || in_disp);
    end

    // any of the three request kinds
    assign active = req.read | req.write | req.fetch;

    // the sequencer and the read mux both rely on a single region bit
    region_onehot: assert final ($onehot(region));

endmodule

// File: mmio_pkg.sv
package mmio_pkg;

    // address map, byte addresses from the cpu
    localparam logic [31:0] ram_base   = 32'h0000_0000;
    localparam logic [31:0] ram_limit  = 32'h0000_ffff;
    localparam logic [31:0] key_addr   = 32'h0001_0000;
    localparam logic [31:0] disp_base  = 32'h0002_0000;
    localparam logic [31:0] disp_limit = 32'h0002_ffff;

    // keypad access delay in cycles
    localparam logic [3:0] key_latency = 4'd3;

    // answer for reads that hit no region
    localparam logic [31:0] unmapped_word = 32'hdeadbeef;

    // wishbone lane select, always a full word
    localparam logic [3:0] wb_sel_all = 4'b1111;

    // keypad status word layout
    localparam int key_valid_bit  = 31;
    localparam int key_app_msb    = 6;
    localparam int key_app_lsb    = 5;
    localparam int key_button_msb = 4;
    localparam int key_button_lsb = 0;

    typedef struct packed {
        logic ram;
        logic key;
        logic disp;
        logic none;
    } region_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
        logic        fetch;
    } cpu_req_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_out_t;

endpackage
